/* src/lsu_params.svh */
// Width and depth macros shared by the LSU packages and modules
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Byte address width of a load or store
`define LSU_ADDR_W 32

// Width of the store data word written to memory
`define LSU_DATA_W 32

// ROB tag width, which sets the number of ops in flight in the core
`define LSU_TAG_W 6

// Number of load queue slots
`define LSU_LQ_DEPTH 8

// Number of store queue entries, kept a power of two for pointer wrap
`define LSU_SQ_DEPTH 8

`endif

/* src/lsu_ops_pkg.sv */
// LSU operation package with the function enum and access size helpers
package lsu_ops_pkg;

    // Loads use codes below 8 and stores set bit 3
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd8,
        SH  = 4'd9,
        SW  = 4'd10
    } lsu_func_t;

    // Bit 3 of the function code marks a store
    function automatic logic is_store(lsu_func_t func);
        return func[3];
    endfunction

    // Number of bytes touched by an access of the given function
    function automatic logic [2:0] access_bytes(lsu_func_t func);
        case (func)
            LB, LBU, SB: return 3'd1;
            LH, LHU, SH: return 3'd2;
            default:     return 3'd4;
        endcase
    endfunction

endpackage

/* src/lsu_tag_pkg.sv */
// ROB bookkeeping package with the tag, load slot index and store pointer types
`include "lsu_params.svh"

package lsu_tag_pkg;

    // Tag that the ROB hands out with each op and uses again on retire
    typedef logic [`LSU_TAG_W-1:0] rob_tag_t;

    // Binary index of one load queue slot
    typedef logic [$clog2(`LSU_LQ_DEPTH)-1:0] lq_idx_t;

    // Store queue pointer, the top bit flips on each wrap
    // Equal indices with different wrap bits mean the queue is full
    typedef logic [$clog2(`LSU_SQ_DEPTH):0] sq_ptr_t;

endpackage

/* src/lsu_id.sv */
// LSU dispatch that routes an issued op to the load queue or the store queue
`include "lsu_params.svh"

module lsu_id (
    // Op issued from the reservation station
    input  logic                      i_issue_en,
    input  lsu_ops_pkg::lsu_func_t    i_issue_func,
    input  lsu_tag_pkg::rob_tag_t     i_issue_tag,
    input  logic [`LSU_ADDR_W-1:0]    i_issue_addr,
    input  logic [`LSU_DATA_W-1:0]    i_issue_data,

    // Room indication from both queues
    input  logic                      i_lq_full,
    input  logic                      i_sq_full,

    output logic                      o_issue_stall,

    // Load queue allocation
    output logic                      o_lq_alloc_en,
    output lsu_tag_pkg::rob_tag_t     o_lq_alloc_tag,
    output logic [`LSU_ADDR_W-1:0]    o_lq_alloc_addr,

    // Store queue allocation
    output logic                      o_sq_alloc_en,
    output lsu_tag_pkg::rob_tag_t     o_sq_alloc_tag,
    output logic [`LSU_ADDR_W-1:0]    o_sq_alloc_addr,
    output logic [`LSU_DATA_W-1:0]    o_sq_alloc_data,
    output lsu_ops_pkg::lsu_func_t    o_sq_alloc_func
);

    // Class of the issued op
    logic issue_is_store;

    // Room left in the queue that the op targets
    logic target_full;

    assign issue_is_store = lsu_ops_pkg::is_store(i_issue_func);

    // Only the queue that would take the op can hold it back
    assign target_full = issue_is_store ? i_sq_full : i_lq_full;

    // The stall is only raised against a live issue strobe
    assign o_issue_stall = i_issue_en && target_full;

    // An accepted op raises exactly one enable
    assign o_lq_alloc_en = i_issue_en && !issue_is_store && !i_lq_full;
    assign o_sq_alloc_en = i_issue_en && issue_is_store && !i_sq_full;

    // Payload fans out to both queues, the enables decide who takes it
    assign o_lq_alloc_tag  = i_issue_tag;
    assign o_lq_alloc_addr = i_issue_addr;

    assign o_sq_alloc_tag  = i_issue_tag;
    assign o_sq_alloc_addr = i_issue_addr;
    assign o_sq_alloc_data = i_issue_data;
    assign o_sq_alloc_func = i_issue_func;

endmodule

/* src/lsu_lq.sv */
// Load queue that holds loads until retire and flags loads hit by a draining store
`include "lsu_params.svh"

module lsu_lq (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      i_flush,

    output logic                      o_full,

    // New load from dispatch
    input  logic                      i_alloc_en,
    input  lsu_tag_pkg::rob_tag_t     i_alloc_tag,
    input  logic [`LSU_ADDR_W-1:0]    i_alloc_addr,

    // Store leaving the store queue towards memory
    input  logic                      i_sq_retire_en,
    input  logic [`LSU_ADDR_W-1:0]    i_sq_retire_addr,
    input  lsu_ops_pkg::lsu_func_t    i_sq_retire_func,

    // Retire port from the ROB
    input  logic                      i_rob_retire_en,
    input  lsu_tag_pkg::rob_tag_t     i_rob_retire_tag,
    output logic                      o_rob_retire_mis_speculated
);

    localparam int DEPTH = `LSU_LQ_DEPTH;

    // Per slot load address and ROB tag
    logic [`LSU_ADDR_W-1:0]  slot_addr [DEPTH];
    lsu_tag_pkg::rob_tag_t   slot_tag  [DEPTH];

    // Per slot state, valid marks an occupied slot
    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] slot_mis;

    // One-hot vectors over the slots
    logic [DEPTH-1:0] empty_vec;
    logic [DEPTH-1:0] alloc_sel;
    logic [DEPTH-1:0] retire_sel;
    logic [DEPTH-1:0] hit_sel;

    logic allocating;
    logic retire_hit;

    lsu_tag_pkg::lq_idx_t retire_idx;

    // Byte range written by the draining store, one bit wider to avoid wrap
    logic [`LSU_ADDR_W:0] st_start;
    logic [`LSU_ADDR_W:0] st_end;

    assign empty_vec = ~slot_valid;
    assign o_full    = ~|empty_vec;

    // Lowest empty slot, isolated by clearing all higher set bits
    assign alloc_sel  = empty_vec & ~(empty_vec - 1'b1);
    assign allocating = i_alloc_en && !o_full && !i_flush;

    // Store window is [addr, addr + bytes)
    assign st_start = {1'b0, i_sq_retire_addr};
    assign st_end   = st_start
                    + {{(`LSU_ADDR_W - 2){1'b0}}, lsu_ops_pkg::access_bytes(i_sq_retire_func)};

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            // A retiring tag can only match an occupied slot
            retire_sel[i] = slot_valid[i] && (slot_tag[i] == i_rob_retire_tag);
            // Load address falls inside the bytes the store writes
            hit_sel[i] = slot_valid[i]
                       && ({1'b0, slot_addr[i]} >= st_start)
                       && ({1'b0, slot_addr[i]} < st_end);
        end
    end

    // Turn the one-hot retire select into a slot number
    always_comb begin
        retire_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (retire_sel[i]) begin
                retire_idx = retire_idx | lsu_tag_pkg::lq_idx_t'(i);
            end
        end
    end

    assign retire_hit = |retire_sel;

    // Flag reported back while the slot is still held, before the retire edge
    assign o_rob_retire_mis_speculated = retire_hit && slot_mis[retire_idx];

    // Slot state, flush empties the whole queue
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
            slot_mis   <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (i_flush) begin
                    slot_valid[i] <= 1'b0;
                end else if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (i_rob_retire_en && retire_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end

                // A new load starts clean, a drain marks every valid overlap
                if (allocating && alloc_sel[i]) begin
                    slot_mis[i] <= 1'b0;
                end else if (i_sq_retire_en && hit_sel[i]) begin
                    slot_mis[i] <= 1'b1;
                end
            end
        end
    end

    // Address and tag only change when the slot is taken
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_addr[i] <= i_alloc_addr;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
    end

    // ROB tags are unique, so two slots never hold the retiring tag
    a_one_retire_slot: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_rob_retire_en |-> $onehot0(retire_sel)
    ) else $error("lsu_lq: retiring tag found in more than one slot");

    // Dispatch must have stalled a load that finds the queue full
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full
    ) else $error("lsu_lq: allocation while full");

endmodule

/* src/lsu_sq.sv */
// In-order store queue that commits stores on retire and drains them to memory
`include "lsu_params.svh"

module lsu_sq (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      i_flush,

    output logic                      o_full,

    // New store from dispatch
    input  logic                      i_alloc_en,
    input  lsu_tag_pkg::rob_tag_t     i_alloc_tag,
    input  logic [`LSU_ADDR_W-1:0]    i_alloc_addr,
    input  logic [`LSU_DATA_W-1:0]    i_alloc_data,
    input  lsu_ops_pkg::lsu_func_t    i_alloc_func,

    // Retire port from the ROB
    input  logic                      i_rob_retire_en,
    input  lsu_tag_pkg::rob_tag_t     i_rob_retire_tag,

    // Memory write port, one write accepted every cycle
    output logic                      o_mem_wr_en,
    output logic [`LSU_ADDR_W-1:0]    o_mem_wr_addr,
    output logic [`LSU_DATA_W-1:0]    o_mem_wr_data,
    output lsu_ops_pkg::lsu_func_t    o_mem_wr_func
);

    localparam int DEPTH = `LSU_SQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // Entry payload
    logic [`LSU_ADDR_W-1:0]  ent_addr [DEPTH];
    logic [`LSU_DATA_W-1:0]  ent_data [DEPTH];
    lsu_ops_pkg::lsu_func_t  ent_func [DEPTH];
    lsu_tag_pkg::rob_tag_t   ent_tag  [DEPTH];

    // Entry state, committed means the ROB has retired the store
    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] ent_committed;

    // Head is the oldest store, tail is the next free entry
    lsu_tag_pkg::sq_ptr_t head;
    lsu_tag_pkg::sq_ptr_t tail;

    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;

    logic [DEPTH-1:0] commit_hit;
    logic [DEPTH-1:0] keep_vec;

    // Number of entries that survive a flush
    lsu_tag_pkg::sq_ptr_t keep_cnt;

    logic allocating;
    logic draining;

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];

    // Same index with opposite wrap bits
    assign o_full = (head[IDX_W] != tail[IDX_W]) && (head_idx == tail_idx);

    assign allocating = i_alloc_en && !o_full && !i_flush;
    assign draining   = ent_valid[head_idx] && ent_committed[head_idx];

    always_comb begin
        keep_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            // Retire commits the one pending store carrying the tag
            commit_hit[i] = i_rob_retire_en && ent_valid[i] && !ent_committed[i]
                          && (ent_tag[i] == i_rob_retire_tag);
            // Stores committed by now or at this edge outlive a flush
            keep_vec[i] = ent_valid[i] && (ent_committed[i] || commit_hit[i]);
            keep_cnt    = keep_cnt + lsu_tag_pkg::sq_ptr_t'(keep_vec[i]);
        end
    end

    // Head entry goes straight to memory once committed
    assign o_mem_wr_en   = draining;
    assign o_mem_wr_addr = ent_addr[head_idx];
    assign o_mem_wr_data = ent_data[head_idx];
    assign o_mem_wr_func = ent_func[head_idx];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head          <= '0;
            tail          <= '0;
            ent_valid     <= '0;
            ent_committed <= '0;
        end else begin
            if (draining) begin
                head <= head + 1'b1;
            end

            // Committed stores form a run from the head, so the tail lands
            // just past the last one
            if (i_flush) begin
                tail <= head + keep_cnt;
            end else if (allocating) begin
                tail <= tail + 1'b1;
            end

            for (int i = 0; i < DEPTH; i++) begin
                if (draining && (i == int'(head_idx))) begin
                    ent_valid[i]     <= 1'b0;
                    ent_committed[i] <= 1'b0;
                end else if (i_flush) begin
                    ent_valid[i]     <= keep_vec[i];
                    ent_committed[i] <= keep_vec[i];
                end else if (allocating && (i == int'(tail_idx))) begin
                    ent_valid[i]     <= 1'b1;
                    ent_committed[i] <= 1'b0;
                end else if (commit_hit[i]) begin
                    ent_committed[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocating) begin
            ent_addr[tail_idx] <= i_alloc_addr;
            ent_data[tail_idx] <= i_alloc_data;
            ent_func[tail_idx] <= i_alloc_func;
            ent_tag[tail_idx]  <= i_alloc_tag;
        end
    end

    // A drain only comes from a queue that the pointers show as occupied
    a_drain_valid: assert property (
        @(posedge clk) disable iff (!n_rst)
        o_mem_wr_en |-> (head != tail)
    ) else $error("lsu_sq: drain from an empty queue");

    // Dispatch must have stalled a store that finds the queue full
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full
    ) else $error("lsu_sq: allocation while full");

endmodule

/* src/lsu.sv */
// LSU top level joining dispatch, load queue and store queue
`include "lsu_params.svh"

module lsu (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      i_flush,

    // Issue port from the reservation station
    input  logic                      i_issue_en,
    input  lsu_ops_pkg::lsu_func_t    i_issue_func,
    input  lsu_tag_pkg::rob_tag_t     i_issue_tag,
    input  logic [`LSU_ADDR_W-1:0]    i_issue_addr,
    input  logic [`LSU_DATA_W-1:0]    i_issue_data,
    output logic                      o_issue_stall,

    // ROB retire port
    input  logic                      i_rob_retire_en,
    input  lsu_tag_pkg::rob_tag_t     i_rob_retire_tag,
    output logic                      o_rob_retire_mis_speculated,

    // Memory write port
    output logic                      o_mem_wr_en,
    output logic [`LSU_ADDR_W-1:0]    o_mem_wr_addr,
    output logic [`LSU_DATA_W-1:0]    o_mem_wr_data,
    output lsu_ops_pkg::lsu_func_t    o_mem_wr_func
);

    logic                      lq_alloc_en;
    lsu_tag_pkg::rob_tag_t     lq_alloc_tag;
    logic [`LSU_ADDR_W-1:0]    lq_alloc_addr;
    logic                      lq_full;

    logic                      sq_alloc_en;
    lsu_tag_pkg::rob_tag_t     sq_alloc_tag;
    logic [`LSU_ADDR_W-1:0]    sq_alloc_addr;
    logic [`LSU_DATA_W-1:0]    sq_alloc_data;
    lsu_ops_pkg::lsu_func_t    sq_alloc_func;
    logic                      sq_full;

    lsu_id u_id (
        .i_issue_en      (i_issue_en),
        .i_issue_func    (i_issue_func),
        .i_issue_tag     (i_issue_tag),
        .i_issue_addr    (i_issue_addr),
        .i_issue_data    (i_issue_data),
        .i_lq_full       (lq_full),
        .i_sq_full       (sq_full),
        .o_issue_stall   (o_issue_stall),
        .o_lq_alloc_en   (lq_alloc_en),
        .o_lq_alloc_tag  (lq_alloc_tag),
        .o_lq_alloc_addr (lq_alloc_addr),
        .o_sq_alloc_en   (sq_alloc_en),
        .o_sq_alloc_tag  (sq_alloc_tag),
        .o_sq_alloc_addr (sq_alloc_addr),
        .o_sq_alloc_data (sq_alloc_data),
        .o_sq_alloc_func (sq_alloc_func)
    );

    // The store write to memory doubles as the overlap probe for loads
    lsu_lq u_lq (
        .clk                         (clk),
        .n_rst                       (n_rst),
        .i_flush                     (i_flush),
        .o_full                      (lq_full),
        .i_alloc_en                  (lq_alloc_en),
        .i_alloc_tag                 (lq_alloc_tag),
        .i_alloc_addr                (lq_alloc_addr),
        .i_sq_retire_en              (o_mem_wr_en),
        .i_sq_retire_addr            (o_mem_wr_addr),
        .i_sq_retire_func            (o_mem_wr_func),
        .i_rob_retire_en             (i_rob_retire_en),
        .i_rob_retire_tag            (i_rob_retire_tag),
        .o_rob_retire_mis_speculated (o_rob_retire_mis_speculated)
    );

    lsu_sq u_sq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .o_full           (sq_full),
        .i_alloc_en       (sq_alloc_en),
        .i_alloc_tag      (sq_alloc_tag),
        .i_alloc_addr     (sq_alloc_addr),
        .i_alloc_data     (sq_alloc_data),
        .i_alloc_func     (sq_alloc_func),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_mem_wr_en      (o_mem_wr_en),
        .o_mem_wr_addr    (o_mem_wr_addr),
        .o_mem_wr_data    (o_mem_wr_data),
        .o_mem_wr_func    (o_mem_wr_func)
    );

endmodule

/* verif/lsu_tb.sv */
// Random-stimulus testbench for the LSU with a model of both queues and the memory write stream
`include "lsu_params.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int N_OPS      = 1500;
    localparam int TAGS       = 1 << `LSU_TAG_W;

    logic                      clk;
    logic                      n_rst;
    logic                      i_flush;
    logic                      i_issue_en;
    lsu_ops_pkg::lsu_func_t    i_issue_func;
    lsu_tag_pkg::rob_tag_t     i_issue_tag;
    logic [`LSU_ADDR_W-1:0]    i_issue_addr;
    logic [`LSU_DATA_W-1:0]    i_issue_data;
    logic                      o_issue_stall;
    logic                      i_rob_retire_en;
    lsu_tag_pkg::rob_tag_t     i_rob_retire_tag;
    logic                      o_rob_retire_mis_speculated;
    logic                      o_mem_wr_en;
    logic [`LSU_ADDR_W-1:0]    o_mem_wr_addr;
    logic [`LSU_DATA_W-1:0]    o_mem_wr_data;
    lsu_ops_pkg::lsu_func_t    o_mem_wr_func;

    integer seed;

    // Loads in flight, indexed by ROB tag
    logic        ld_live [TAGS];
    logic [31:0] ld_addr [TAGS];
    logic        ld_flag [TAGS];
    int          lq_cnt;

    // Store queue model, element 0 is the oldest store
    logic [31:0]            sq_addr [$];
    logic [31:0]            sq_data [$];
    lsu_ops_pkg::lsu_func_t sq_func [$];
    lsu_tag_pkg::rob_tag_t  sq_tag  [$];
    logic                   sq_comm [$];

    // Accepted ops in program order that the ROB has not retired yet
    lsu_tag_pkg::rob_tag_t  rob_tag   [$];
    logic                   rob_store [$];

    // Op waiting to be issued, it stays here while stalled
    logic                   have_op;
    logic                   op_store;
    lsu_ops_pkg::lsu_func_t op_func;
    logic [31:0]            op_addr;
    logic [31:0]            op_data;
    lsu_tag_pkg::rob_tag_t  op_tag;

    int issued;
    int accepted;
    int errors;
    int checks;
    int writes;
    int flagged;
    int flushes;
    int lq_stalls;
    int sq_stalls;

    lsu dut0 (
        .clk                         (clk),
        .n_rst                       (n_rst),
        .i_flush                     (i_flush),
        .i_issue_en                  (i_issue_en),
        .i_issue_func                (i_issue_func),
        .i_issue_tag                 (i_issue_tag),
        .i_issue_addr                (i_issue_addr),
        .i_issue_data                (i_issue_data),
        .o_issue_stall               (o_issue_stall),
        .i_rob_retire_en             (i_rob_retire_en),
        .i_rob_retire_tag            (i_rob_retire_tag),
        .o_rob_retire_mis_speculated (o_rob_retire_mis_speculated),
        .o_mem_wr_en                 (o_mem_wr_en),
        .o_mem_wr_addr               (o_mem_wr_addr),
        .o_mem_wr_data               (o_mem_wr_data),
        .o_mem_wr_func               (o_mem_wr_func)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Bytes written or read by each function, taken from the RISC-V ISA
    function automatic logic [31:0] byte_count(lsu_ops_pkg::lsu_func_t func);
        case (func)
            lsu_ops_pkg::LB, lsu_ops_pkg::LBU, lsu_ops_pkg::SB: return 32'd1;
            lsu_ops_pkg::LH, lsu_ops_pkg::LHU, lsu_ops_pkg::SH: return 32'd2;
            default: return 32'd4;
        endcase
    endfunction

    task automatic log_error(string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // New op in a 16 byte window, naturally aligned so that overlaps and near misses occur
    task automatic make_op();
        logic [31:0] r;
        logic [1:0]  off;
        r = $random(seed);
        op_store = r[3];
        if (op_store) begin
            case (r[1:0])
                2'd0:    op_func = lsu_ops_pkg::SB;
                2'd1:    op_func = lsu_ops_pkg::SH;
                default: op_func = lsu_ops_pkg::SW;
            endcase
        end else begin
            case (r[2:0])
                3'd0:    op_func = lsu_ops_pkg::LB;
                3'd1:    op_func = lsu_ops_pkg::LBU;
                3'd2:    op_func = lsu_ops_pkg::LH;
                3'd3:    op_func = lsu_ops_pkg::LHU;
                default: op_func = lsu_ops_pkg::LW;
            endcase
        end
        case (byte_count(op_func))
            32'd1:   off = r[5:4];
            32'd2:   off = {r[5], 1'b0};
            default: off = 2'd0;
        endcase
        op_addr = {28'h000_0200, r[7:6], off};
        op_data = $random(seed);
        op_tag  = lsu_tag_pkg::rob_tag_t'(issued % TAGS);
        issued++;
        have_op = 1'b1;
    endtask

    // A drained store hits every load in flight whose address it wrote
    task automatic mark_overlaps(logic [31:0] addr, lsu_ops_pkg::lsu_func_t func);
        logic [31:0] last;
        last = addr + byte_count(func);
        for (int i = 0; i < TAGS; i++) begin
            if (ld_live[i] && ld_addr[i] >= addr && ld_addr[i] < last) begin
                ld_flag[i] = 1'b1;
            end
        end
    endtask

    task automatic commit_store(lsu_tag_pkg::rob_tag_t tag);
        logic found;
        found = 1'b0;
        for (int i = 0; i < sq_tag.size(); i++) begin
            if (!found && !sq_comm[i] && sq_tag[i] == tag) begin
                sq_comm[i] = 1'b1;
                found = 1'b1;
            end
        end
        if (!found) begin
            log_error($sformatf("model lost retired store tag %0d", tag));
        end
    endtask

    // Loads and uncommitted stores vanish, committed stores sit at the front and stay
    task automatic flush_model();
        for (int i = 0; i < TAGS; i++) begin
            ld_live[i] = 1'b0;
            ld_flag[i] = 1'b0;
        end
        lq_cnt = 0;
        rob_tag.delete();
        rob_store.delete();
        while (sq_comm.size() > 0 && !sq_comm[sq_comm.size() - 1]) begin
            void'(sq_addr.pop_back());
            void'(sq_data.pop_back());
            void'(sq_func.pop_back());
            void'(sq_tag.pop_back());
            void'(sq_comm.pop_back());
        end
    endtask

    // Watchdog sized from the number of ops
    initial begin
        #(N_OPS * 20 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", N_OPS * 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic                  do_issue;
        logic                  do_retire;
        logic                  do_flush;
        logic                  exp_stall;
        logic                  exp_wr;
        logic [31:0]           r;
        lsu_tag_pkg::rob_tag_t rt;
        int                    cycle;
        seed = 32'h92abbfbd;
        clk = 1'b0;
        n_rst            <= 1'b0;
        i_flush          <= 1'b0;
        i_issue_en       <= 1'b0;
        i_issue_func     <= lsu_ops_pkg::LW;
        i_issue_tag      <= '0;
        i_issue_addr     <= '0;
        i_issue_data     <= '0;
        i_rob_retire_en  <= 1'b0;
        i_rob_retire_tag <= '0;
        have_op = 1'b0;
        cycle = 0;
        flush_model();
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        if (o_mem_wr_en !== 1'b0 || o_issue_stall !== 1'b0) begin
            log_error("write enable or stall not low after reset");
        end

        while (accepted < N_OPS || rob_tag.size() > 0 || sq_addr.size() > 0) begin
            @(posedge clk);
            r = $random(seed);
            cycle++;
            do_flush  = (accepted < N_OPS) && (r[5:0] == 6'd0);
            do_issue  = 1'b0;
            do_retire = 1'b0;
            if (!do_flush) begin
                if (accepted < N_OPS && !have_op && r[8:6] != 3'd0) begin
                    make_op();
                end
                do_issue = have_op;
                // Slow retire phases fill the queues and fast ones empty them
                if (rob_tag.size() > 0) begin
                    if (accepted >= N_OPS) begin
                        do_retire = 1'b1;
                    end else if (cycle[6]) begin
                        do_retire = (r[10:9] == 2'd0);
                    end else begin
                        do_retire = (r[10:9] != 2'd0);
                    end
                end
            end
            i_flush         <= do_flush;
            i_issue_en      <= do_issue;
            i_issue_func    <= op_func;
            i_issue_tag     <= op_tag;
            i_issue_addr    <= op_addr;
            i_issue_data    <= op_data;
            i_rob_retire_en <= do_retire;
            if (do_retire) begin
                i_rob_retire_tag <= rob_tag[0];
            end

            @(negedge clk);
            exp_stall = 1'b0;
            if (do_issue) begin
                exp_stall = op_store ? (sq_addr.size() == `LSU_SQ_DEPTH)
                                     : (lq_cnt == `LSU_LQ_DEPTH);
            end
            checks++;
            if (o_issue_stall !== exp_stall) begin
                log_error($sformatf("issue stall %b, expected %b", o_issue_stall, exp_stall));
            end
            if (do_retire && !rob_store[0]) begin
                checks++;
                if (ld_flag[rob_tag[0]]) begin
                    flagged++;
                end
                if (o_rob_retire_mis_speculated !== ld_flag[rob_tag[0]]) begin
                    log_error($sformatf("load tag %0d mis-speculated %b, expected %b",
                        rob_tag[0], o_rob_retire_mis_speculated, ld_flag[rob_tag[0]]));
                end
            end
            exp_wr = (sq_addr.size() > 0) && sq_comm[0];
            checks++;
            if (o_mem_wr_en !== exp_wr) begin
                log_error($sformatf("memory write enable %b, expected %b", o_mem_wr_en, exp_wr));
            end else if (exp_wr) begin
                if (o_mem_wr_addr !== sq_addr[0] || o_mem_wr_data !== sq_data[0]
                        || o_mem_wr_func !== sq_func[0]) begin
                    log_error($sformatf("write %h/%h/%h, expected %h/%h/%h",
                        o_mem_wr_addr, o_mem_wr_data, o_mem_wr_func,
                        sq_addr[0], sq_data[0], sq_func[0]));
                end
            end

            // Model state after the coming edge, drains first so a new load misses them
            if (exp_wr) begin
                mark_overlaps(sq_addr[0], sq_func[0]);
                void'(sq_addr.pop_front());
                void'(sq_data.pop_front());
                void'(sq_func.pop_front());
                void'(sq_tag.pop_front());
                void'(sq_comm.pop_front());
                writes++;
            end
            if (do_retire) begin
                rt = rob_tag.pop_front();
                if (rob_store.pop_front()) begin
                    commit_store(rt);
                end else begin
                    ld_live[rt] = 1'b0;
                    lq_cnt--;
                end
            end
            if (do_issue && !exp_stall) begin
                rob_tag.push_back(op_tag);
                rob_store.push_back(op_store);
                if (op_store) begin
                    sq_addr.push_back(op_addr);
                    sq_data.push_back(op_data);
                    sq_func.push_back(op_func);
                    sq_tag.push_back(op_tag);
                    sq_comm.push_back(1'b0);
                end else begin
                    ld_live[op_tag] = 1'b1;
                    ld_addr[op_tag] = op_addr;
                    ld_flag[op_tag] = 1'b0;
                    lq_cnt++;
                end
                have_op = 1'b0;
                accepted++;
            end else if (do_issue && flushes > 0) begin
                // Stalls after a flush show that the queues refill to full depth
                if (op_store) begin
                    sq_stalls++;
                end else begin
                    lq_stalls++;
                end
            end
            if (do_flush) begin
                flush_model();
                flushes++;
            end
        end

        @(posedge clk);
        i_issue_en      <= 1'b0;
        i_rob_retire_en <= 1'b0;
        i_flush         <= 1'b0;
        @(negedge clk);
        if (o_mem_wr_en !== 1'b0) begin
            log_error("memory write after the store queue drained");
        end
        if (lq_stalls == 0 || sq_stalls == 0) begin
            errors++;
            $display("A queue never filled up again after a flush");
        end

        $display("Checks %0d, writes %0d, flagged loads %0d, flushes %0d, stalls %0d/%0d, errors %0d",
            checks, writes, flagged, flushes, lq_stalls, sq_stalls, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* lsu.f */
+incdir+src
src/lsu_ops_pkg.sv
src/lsu_tag_pkg.sv
src/lsu_id.sv
src/lsu_lq.sv
src/lsu_sq.sv
src/lsu.sv
verif/lsu_tb.sv

/* Makefile */
# Verilator build and run of the LSU testbench

SRCS := $(filter-out +%,$(shell cat lsu.f)) src/lsu_params.svh

.PHONY: run clean

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation completed successfully" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vlsu_tb: lsu.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f lsu.f --top-module lsu_tb

clean:
	rm -rf obj_dir sim.log
